/* rtl/st_source_pkg.sv */
//--------------------------------------------------------------------------
// streaming source engine shared definitions
// widths, APB register map and the transaction record
//--------------------------------------------------------------------------
package st_source_pkg;

   // stream field widths
   localparam int data_w    = 32;
   localparam int channel_w = 4;
   localparam int idle_w    = 8;
   // stall counter saturates at all ones
   localparam int lat_w     = 16;

   // fifo sizing, level needs one bit more than the pointer
   localparam int txn_depth  = 16;
   localparam int resp_depth = 16;
   localparam int level_w    = 5;

   localparam int addr_w = 4;

   typedef logic [data_w-1:0]    st_data_t;
   typedef logic [channel_w-1:0] st_channel_t;
   typedef logic [idle_w-1:0]    idle_t;
   typedef logic [lat_w-1:0]     latency_t;
   typedef logic [addr_w-1:0]    apb_addr_t;

   // ------------------------------------------------------------------------
   // register map
   // ------------------------------------------------------------------------
   // ctrl: bit 0 sop, bit 1 eop, bits 7:4 channel, bits 23:16 idles
   localparam apb_addr_t reg_ctrl   = 4'h0;
   // data: write pushes one transaction
   localparam apb_addr_t reg_data   = 4'h4;
   // status: txn level, resp level, complete, sticky overflow
   localparam apb_addr_t reg_status = 4'h8;
   // resp: read pops one latency
   localparam apb_addr_t reg_resp   = 4'hC;

   // one queued beat, 46 bits
   typedef struct packed {
      idle_t       idles;
      logic        sop;
      logic        eop;
      st_channel_t channel;
      st_data_t    data;
   } st_txn_t;

endpackage

/* rtl/sync_fifo.sv */
//--------------------------------------------------------------------------
// synchronous FIFO, circular buffer with any packed payload type
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module sync_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  depth     = 16
) (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         push,
   input  payload_t                     push_data,
   input  logic                         pop,
   output payload_t                     pop_data,
   output logic                         empty,
   output logic                         full,
   output logic [$clog2(depth+1)-1:0]   level
);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int lvl_w = $clog2(depth + 1);

   payload_t               mem [depth];
   logic [ptr_w-1:0]       wr_ptr;
   logic [ptr_w-1:0]       rd_ptr;
   logic [lvl_w-1:0]       count;
   logic                   do_push;
   logic                   do_pop;

   // push while full and pop while empty are dropped
   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   assign empty    = (count == '0);
   assign full     = (count == lvl_w'(depth));
   assign level    = count;
   // head entry is always visible
   assign pop_data = mem[rd_ptr];

   // storage, written only on an accepted push
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // pointers wrap at depth, so depth need not be a power of two
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // simultaneous push and pop leave the count alone
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

/* rtl/apb_csr.sv */
//--------------------------------------------------------------------------
// APB register block, builds transactions from ctrl and data writes,
// pops back-pressure latencies and reports the status word
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module apb_csr (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 psel,
   input  logic                                 penable,
   input  logic                                 pwrite,
   input  st_source_pkg::apb_addr_t             paddr,
   input  logic [31:0]                          pwdata,
   input  logic                                 txn_full,
   input  logic [st_source_pkg::level_w-1:0]    txn_level,
   input  logic                                 resp_empty,
   input  logic                                 resp_full,
   input  logic [st_source_pkg::level_w-1:0]    resp_level,
   input  st_source_pkg::latency_t              resp_out,
   input  logic                                 resp_push,
   input  logic                                 driver_busy,
   output logic [31:0]                          prdata,
   output logic                                 pready,
   output logic                                 pslverr,
   output logic                                 txn_push,
   output st_source_pkg::st_txn_t               txn_in,
   output logic                                 resp_pop
);

   import st_source_pkg::*;

   logic          access;
   logic          ctrl_wr;
   logic          data_wr;
   logic          status_rd;
   logic          resp_rd;
   logic          complete;
   logic [31:0]   status_word;

   // held control fields, reused by every following data write
   logic          ctrl_sop;
   logic          ctrl_eop;
   st_channel_t   ctrl_channel;
   idle_t         ctrl_idles;
   // sticky response overflow
   logic          resp_ovf;

   // no wait states
   assign pready = 1'b1;

   // ------------------------------------------------------------------------
   // access phase decode
   // ------------------------------------------------------------------------
   assign access    = psel && penable;
   assign ctrl_wr   = access && pwrite && (paddr == reg_ctrl);
   assign data_wr   = access && pwrite && (paddr == reg_data);
   assign status_rd = access && !pwrite && (paddr == reg_status);
   assign resp_rd   = access && !pwrite && (paddr == reg_resp);

   // transaction = ctrl fields merged with the written data word
   assign txn_in.idles   = ctrl_idles;
   assign txn_in.sop     = ctrl_sop;
   assign txn_in.eop     = ctrl_eop;
   assign txn_in.channel = ctrl_channel;
   assign txn_in.data    = pwdata;

   // a full txn fifo drops the write, an empty resp fifo gives no pop
   assign txn_push = data_wr && !txn_full;
   assign resp_pop = resp_rd && !resp_empty;
   assign pslverr  = (data_wr && txn_full) || (resp_rd && resp_empty);

   // nothing queued, nothing held and no idle countdown running
   assign complete = (txn_level == '0) && !driver_busy;

   // 17 overflow, 16 complete, 12:8 resp level, 4:0 txn level
   assign status_word = {14'd0, resp_ovf, complete, 3'd0, resp_level, 3'd0, txn_level};

   // read mux, everything write only or unmapped reads 0
   always_comb begin
      prdata = '0;
      if (status_rd) begin
         prdata = status_word;
      end else if (resp_rd && !resp_empty) begin
         prdata = 32'(resp_out);
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ctrl_sop     <= 1'b0;
         ctrl_eop     <= 1'b0;
         ctrl_channel <= '0;
         ctrl_idles   <= '0;
         resp_ovf     <= 1'b0;
      end else begin
         if (ctrl_wr) begin
            ctrl_sop     <= pwdata[0];
            ctrl_eop     <= pwdata[1];
            ctrl_channel <= pwdata[7:4];
            ctrl_idles   <= pwdata[23:16];
         end
         // monitor pushed into a full resp fifo, record lost
         if (resp_push && resp_full) begin
            resp_ovf <= 1'b1;
         end
      end
   end

endmodule

/* rtl/beat_driver.sv */
//--------------------------------------------------------------------------
// stream beat driver, idle countdown then one valid beat held until
// the sink takes it
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module beat_driver (
   input  logic                          clk,
   input  logic                          reset,
   input  st_source_pkg::st_txn_t        txn_out,
   input  logic                          txn_empty,
   input  logic                          src_ready,
   output logic                          txn_pop,
   output logic                          src_valid,
   output st_source_pkg::st_data_t       src_data,
   output st_source_pkg::st_channel_t    src_channel,
   output logic                          src_sop,
   output logic                          src_eop,
   output logic                          driver_busy
);

   import st_source_pkg::*;

   // current transaction payload
   st_txn_t    txn_q;
   // beat on the port
   logic       valid_q;
   // idle countdown running, valid stays low
   logic       counting;
   idle_t      idle_cnt;
   logic       accept;

   assign accept = valid_q && src_ready;

   // --------------------------------------------------------------------------
   // fetch
   // --------------------------------------------------------------------------
   // take the next txn when nothing is loaded, or in the cycle the held
   // beat is accepted so back-to-back beats have no bubble
   assign txn_pop = !txn_empty && (!(valid_q || counting) || accept);

   assign driver_busy = valid_q || counting;

   // fields only show while valid, idle outputs are zero
   assign src_valid   = valid_q;
   assign src_data    = valid_q ? txn_q.data    : '0;
   assign src_channel = valid_q ? txn_q.channel : '0;
   assign src_sop     = valid_q && txn_q.sop;
   assign src_eop     = valid_q && txn_q.eop;

   // payload register, loaded on every pop
   always_ff @(posedge clk) begin
      if (txn_pop) begin
         txn_q <= txn_out;
      end
   end

   // --------------------------------------------------------------------------
   // beat control
   // --------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         valid_q  <= 1'b0;
         counting <= 1'b0;
         idle_cnt <= '0;
      end else begin
         if (txn_pop) begin
            if (txn_out.idles == '0) begin
               // zero idles, beat valid the next cycle
               valid_q  <= 1'b1;
               counting <= 1'b0;
            end else begin
               valid_q  <= 1'b0;
               counting <= 1'b1;
               idle_cnt <= txn_out.idles;
            end
         end else if (counting) begin
            // last idle cycle, raise valid after it
            if (idle_cnt == idle_t'(1)) begin
               counting <= 1'b0;
               valid_q  <= 1'b1;
            end
            idle_cnt <= idle_cnt - 1'b1;
         end else if (accept) begin
            // taken and nothing queued
            valid_q <= 1'b0;
         end
      end
   end

endmodule

/* rtl/backpressure_monitor.sv */
//--------------------------------------------------------------------------
// back-pressure monitor, counts stall cycles of each beat and emits the
// count as a response record on acceptance
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module backpressure_monitor (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       src_valid,
   input  logic                       src_ready,
   output logic                       resp_push,
   output st_source_pkg::latency_t    resp_latency
);

   import st_source_pkg::*;

   latency_t   stall_cnt;
   logic       accept;
   logic       stall;

   assign accept = src_valid && src_ready;
   assign stall  = src_valid && !src_ready;

   // record leaves in the acceptance cycle with the count so far
   assign resp_push    = accept;
   assign resp_latency = stall_cnt;

   // saturating stall counter, cleared once the beat is taken
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         stall_cnt <= '0;
      end else if (accept) begin
         stall_cnt <= '0;
      end else if (stall && (stall_cnt != '1)) begin
         stall_cnt <= stall_cnt + 1'b1;
      end
   end

endmodule

/* rtl/st_source.sv */
//--------------------------------------------------------------------------
// streaming source engine top, APB in, valid/ready beats out
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module st_source (
   input  logic                          clk,
   input  logic                          reset,
   // APB slave
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  st_source_pkg::apb_addr_t      paddr,
   input  logic [31:0]                   pwdata,
   output logic [31:0]                   prdata,
   output logic                          pready,
   output logic                          pslverr,
   // stream source
   output logic                          src_valid,
   output st_source_pkg::st_data_t       src_data,
   output st_source_pkg::st_channel_t    src_channel,
   output logic                          src_sop,
   output logic                          src_eop,
   input  logic                          src_ready
);

   import st_source_pkg::*;

   // transaction path
   logic                 txn_push;
   st_txn_t              txn_in;
   logic                 txn_pop;
   st_txn_t              txn_out;
   logic                 txn_empty;
   logic                 txn_full;
   logic [level_w-1:0]   txn_level;

   // response path
   logic                 resp_push;
   latency_t             resp_latency;
   logic                 resp_pop;
   latency_t             resp_out;
   logic                 resp_empty;
   logic                 resp_full;
   logic [level_w-1:0]   resp_level;

   logic                 driver_busy;

   apb_csr u_csr (
      .clk         (clk),
      .reset       (reset),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .txn_full    (txn_full),
      .txn_level   (txn_level),
      .resp_empty  (resp_empty),
      .resp_full   (resp_full),
      .resp_level  (resp_level),
      .resp_out    (resp_out),
      .resp_push   (resp_push),
      .driver_busy (driver_busy),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .txn_push    (txn_push),
      .txn_in      (txn_in),
      .resp_pop    (resp_pop)
   );

   sync_fifo #(.payload_t(st_txn_t), .depth(txn_depth)) txn_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (txn_push),
      .push_data (txn_in),
      .pop       (txn_pop),
      .pop_data  (txn_out),
      .empty     (txn_empty),
      .full      (txn_full),
      .level     (txn_level)
   );

   beat_driver u_driver (
      .clk         (clk),
      .reset       (reset),
      .txn_out     (txn_out),
      .txn_empty   (txn_empty),
      .src_ready   (src_ready),
      .txn_pop     (txn_pop),
      .src_valid   (src_valid),
      .src_data    (src_data),
      .src_channel (src_channel),
      .src_sop     (src_sop),
      .src_eop     (src_eop),
      .driver_busy (driver_busy)
   );

   // monitor watches the port as the sink sees it
   backpressure_monitor u_monitor (
      .clk          (clk),
      .reset        (reset),
      .src_valid    (src_valid),
      .src_ready    (src_ready),
      .resp_push    (resp_push),
      .resp_latency (resp_latency)
   );

   sync_fifo #(.payload_t(latency_t), .depth(resp_depth)) resp_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (resp_push),
      .push_data (resp_latency),
      .pop       (resp_pop),
      .pop_data  (resp_out),
      .empty     (resp_empty),
      .full      (resp_full),
      .level     (resp_level)
   );

endmodule

/* verif/st_source_tb.sv */
//--------------------------------------------------------------------------
// streaming source engine testbench, APB writes from a stimulus table,
// random back-pressure, beat, idle gap, latency and status checks
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module st_source_tb;

   import st_source_pkg::*;

   // one stimulus row, lcg selects random ready while this beat is up
   typedef struct packed {
      st_data_t    data;
      logic        sop;
      logic        eop;
      st_channel_t channel;
      idle_t       idles;
      logic        lcg;
   } entry_t;

   localparam int n_stim      = 12;
   // one txn sits in the driver, so the fifo refuses write depth+2
   localparam int fill_writes = txn_depth + 2;
   localparam int wd_cycles   = 200 * (n_stim + fill_writes) + 1000;

   logic          clk;
   logic          reset;
   logic          psel;
   logic          penable;
   logic          pwrite;
   apb_addr_t     paddr;
   logic [31:0]   pwdata;
   logic [31:0]   prdata;
   logic          pready;
   logic          pslverr;
   logic          src_valid;
   st_data_t      src_data;
   st_channel_t   src_channel;
   logic          src_sop;
   logic          src_eop;
   logic          src_ready;

   entry_t        stim [n_stim];
   // beats written and not yet seen, stall counts in beat order
   entry_t        exp_q [$];
   latency_t      lat_q [$];
   logic [31:0]   seed        = 32'h9ab3_1264;
   logic          ready_hold  = 1'b1;
   latency_t      stall_cnt   = '0;
   int            gap_cnt     = 0;
   logic          track_gap   = 1'b0;
   logic          was_stalled = 1'b0;

   st_source uut (.*);

   initial begin : clock_gen
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // reporting and compare tasks
   // ------------------------------------------------------------------------
   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         report_fail($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
      end
   endtask

   task automatic check_beat(input st_data_t data, input st_channel_t ch, input logic sop,
                             input logic eop, input entry_t e);
      if (data !== e.data || ch !== e.channel || sop !== e.sop || eop !== e.eop) begin
         report_fail($sformatf("ERR %0t: beat %h ch %h sop %b eop %b, exp %h ch %h sop %b eop %b",
                               $time, data, ch, sop, eop, e.data, e.channel, e.sop, e.eop));
      end
   endtask

   task automatic check_idles(input idle_t got, input idle_t exp);
      if (got !== exp) begin
         report_fail($sformatf("ERR %0t: %0d idle cycles, expected %0d", $time, got, exp));
      end
   endtask

   task automatic check_latency(input latency_t got, input latency_t exp);
      if (got !== exp) begin
         report_fail($sformatf("ERR %0t: latency %0d, expected %0d", $time, got, exp));
      end
   endtask

   task automatic check_status(input logic [31:0] word, input logic [level_w-1:0] txn_lvl,
                               input logic [level_w-1:0] resp_lvl, input logic complete,
                               input logic ovf);
      if (word[4:0] !== txn_lvl || word[12:8] !== resp_lvl || word[16] !== complete ||
          word[17] !== ovf) begin
         report_fail($sformatf("ERR %0t: status %h, expected txn %0d resp %0d done %b ovf %b",
                               $time, word, txn_lvl, resp_lvl, complete, ovf));
      end
   endtask

   // ------------------------------------------------------------------------
   // APB master, setup then access phase, no wait states
   // ------------------------------------------------------------------------
   task automatic apb_access(input logic write, input apb_addr_t addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
      @(posedge clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #1;
      penable = 1'b1;
      // prdata and pslverr settle mid access phase
      @(negedge clk);
      check_bit("pready in access phase", pready, 1'b1);
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input apb_addr_t addr, input logic [31:0] data, output logic err);
      logic [31:0] unused;
      apb_access(1'b1, addr, data, unused, err);
   endtask

   task automatic apb_read(input apb_addr_t addr, output logic [31:0] data, output logic err);
      apb_access(1'b0, addr, '0, data, err);
   endtask

   task automatic expect_status(input logic [level_w-1:0] txn_lvl,
                                input logic [level_w-1:0] resp_lvl, input logic complete,
                                input logic ovf);
      logic [31:0] word;
      logic        err;
      apb_read(reg_status, word, err);
      check_bit("pslverr on status read", err, 1'b0);
      check_status(word, txn_lvl, resp_lvl, complete, ovf);
   endtask

   // pop one latency and match it against the counted stalls
   task automatic read_latency();
      logic [31:0] word;
      logic        err;
      apb_read(reg_resp, word, err);
      check_bit("pslverr on response read", err, 1'b0);
      if (lat_q.size() == 0) begin
         report_fail("a response was read but no beat was counted for it");
      end
      check_latency(latency_t'(word), lat_q.pop_front());
   endtask

   task automatic drain();
      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (2) @(posedge clk);
   endtask

   function automatic logic [31:0] ctrl_word(input entry_t e);
      return {8'd0, e.idles, 8'd0, e.channel, 2'd0, e.eop, e.sop};
   endfunction

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // data, sop, eop, channel, idles, lcg ready
   task automatic fill_table();
      stim[0]  = '{32'h1111_0001, 1'b1, 1'b0, 4'h1, 8'd0, 1'b0};
      stim[1]  = '{32'h2222_0002, 1'b0, 1'b0, 4'h1, 8'd0, 1'b0};
      stim[2]  = '{32'h3333_0003, 1'b0, 1'b1, 4'h1, 8'd3, 1'b0};
      stim[3]  = '{32'h4444_0004, 1'b1, 1'b1, 4'h2, 8'd1, 1'b0};
      stim[4]  = '{32'h5555_0005, 1'b1, 1'b0, 4'h3, 8'd0, 1'b0};
      stim[5]  = '{32'h6666_0006, 1'b0, 1'b1, 4'h3, 8'd5, 1'b0};
      stim[6]  = '{32'h7777_0007, 1'b1, 1'b0, 4'h4, 8'd0, 1'b1};
      stim[7]  = '{32'h8888_0008, 1'b0, 1'b0, 4'h4, 8'd2, 1'b1};
      stim[8]  = '{32'h9999_0009, 1'b0, 1'b0, 4'h4, 8'd0, 1'b1};
      stim[9]  = '{32'haaaa_000a, 1'b0, 1'b1, 4'h4, 8'd4, 1'b1};
      stim[10] = '{32'hbbbb_000b, 1'b1, 1'b0, 4'hf, 8'd1, 1'b1};
      stim[11] = '{32'hcccc_000c, 1'b0, 1'b1, 4'hf, 8'd0, 1'b1};
   endtask

   // ------------------------------------------------------------------------
   // sink side
   // ------------------------------------------------------------------------
   // ready follows the mode of the beat that is expected next
   initial begin : ready_gen
      forever begin
         @(posedge clk);
         #1;
         seed = lcg_next(seed);
         if (ready_hold) begin
            src_ready = 1'b0;
         end else if (exp_q.size() != 0 && exp_q[0].lcg) begin
            src_ready = seed[16];
         end else begin
            src_ready = 1'b1;
         end
      end
   end

   // port scoreboard, sampled mid cycle where everything is stable
   always @(negedge clk) begin : scoreboard
      entry_t e;
      if (!reset) begin
         if (was_stalled) begin
            check_bit("src_valid under back-pressure", src_valid, 1'b1);
         end
         if (!src_valid) begin
            // idle outputs drive zero
            check_beat(src_data, src_channel, src_sop, src_eop, '0);
            gap_cnt++;
         end else begin
            if (exp_q.size() == 0) begin
               report_fail("a beat appeared on the stream port that was never written");
            end
            e = exp_q[0];
            // gap only meaningful when this txn was queued at the last acceptance
            if (track_gap) begin
               check_idles(idle_t'(gap_cnt), e.idles);
            end
            track_gap = 1'b0;
            gap_cnt   = 0;
            check_beat(src_data, src_channel, src_sop, src_eop, e);
            if (src_ready) begin
               lat_q.push_back(stall_cnt);
               stall_cnt = '0;
               void'(exp_q.pop_front());
               track_gap = (exp_q.size() != 0);
            end else begin
               stall_cnt++;
            end
         end
         was_stalled = src_valid && !src_ready;
      end
   end

   initial begin : watchdog
      repeat (wd_cycles) @(posedge clk);
      report_fail($sformatf("watchdog expired after %0d cycles, the run stalled", wd_cycles));
   end

   // ------------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------------
   initial begin : main
      logic [31:0] rdata;
      logic        err;
      entry_t      fill_e;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      src_ready = 1'b0;
      reset     = 1'b1;
      fill_table();
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      @(negedge clk);
      check_bit("src_valid after reset", src_valid, 1'b0);
      check_bit("pslverr after reset", pslverr, 1'b0);

      // queue the whole table with ready low, then let it flow
      for (int i = 0; i < n_stim; i++) begin
         apb_write(reg_ctrl, ctrl_word(stim[i]), err);
         check_bit("pslverr on ctrl write", err, 1'b0);
         exp_q.push_back(stim[i]);
         apb_write(reg_data, stim[i].data, err);
         check_bit("pslverr on data write", err, 1'b0);
      end
      ready_hold = 1'b0;
      drain();
      expect_status('0, level_w'(n_stim), 1'b1, 1'b0);
      for (int i = 0; i < n_stim; i++) begin
         read_latency();
      end
      expect_status('0, '0, 1'b1, 1'b0);

      // empty response fifo
      apb_read(reg_resp, rdata, err);
      check_bit("pslverr on empty response read", err, 1'b1);
      check_latency(latency_t'(rdata), '0);

      // fill the txn fifo with the sink stalled, last write is refused
      ready_hold = 1'b1;
      fill_e     = '{32'h0, 1'b1, 1'b1, 4'h5, 8'd0, 1'b0};
      apb_write(reg_ctrl, ctrl_word(fill_e), err);
      check_bit("pslverr on ctrl write", err, 1'b0);
      for (int i = 0; i < fill_writes; i++) begin
         fill_e.data = 32'hc0de_0000 + 32'(i);
         if (i < fill_writes - 1) begin
            exp_q.push_back(fill_e);
         end
         apb_write(reg_data, fill_e.data, err);
         check_bit("pslverr on fill write", err, i == fill_writes - 1);
      end
      expect_status(level_w'(txn_depth), '0, 1'b0, 1'b0);

      // 17 beats into a 16 deep response fifo sets overflow
      ready_hold = 1'b0;
      drain();
      expect_status('0, level_w'(resp_depth), 1'b1, 1'b1);
      for (int i = 0; i < resp_depth; i++) begin
         read_latency();
      end
      expect_status('0, '0, 1'b1, 1'b1);

      $display("Result: PASSED");
      $finish;
   end

endmodule

/* st_source.f */
rtl/st_source_pkg.sv
rtl/sync_fifo.sv
rtl/apb_csr.sv
rtl/beat_driver.sv
rtl/backpressure_monitor.sv
rtl/st_source.sv
verif/st_source_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile the st_source testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module st_source_tb \
   -f st_source.f -o st_source_sim \
   || { echo "compile failed"; exit 1; }

./obj_dir/st_source_sim > sim.log 2>&1
cat sim.log

grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "no pass line in the log"; exit 1; }
echo "simulation passed"
exit 0
